//--- mpdma_settings.svh
// Build-time sizes for the mirror-padding DMA engine
// Bus widths, matrix dimension field, window and block element counts
`ifndef MPDMA_SETTINGS_SVH
`define MPDMA_SETTINGS_SVH

// Byte address width of the AXI ports
`define MPDMA_ADDR_W 32

// One matrix element per bus word
`define MPDMA_DATA_W 32

`define MPDMA_DIM_W 6  // Width field and output block coordinates

// 3x3 source window fetched per block
`define MPDMA_WIN_N 9

// 2x2 output block written per window
`define MPDMA_BLK_N 4

`define MPDMA_WORD_BYTES 4  // Byte stride between elements

`endif

//--- mpdma_pkg.sv
// Shared types for the mirror-padding DMA engine
// Word and coordinate vectors, configuration and position structs,
// AXI payload structs, controller states and the window origin helper
`default_nettype none

`include "mpdma_settings.svh"

package mpdma_pkg;

    typedef logic [`MPDMA_ADDR_W-1:0] addr_t;
    typedef logic [`MPDMA_DATA_W-1:0] data_t;
    typedef logic [`MPDMA_DIM_W-1:0]  dim_t;

    typedef struct packed {
        addr_t src_addr;
        addr_t dst_addr;
        dim_t  mat_width;  // W, even, 2 to 62
    } cfg_t;

    // 0-based output coordinates of the block's top-left word
    typedef struct packed {
        dim_t block_row;
        dim_t block_col;
    } blk_pos_t;

    typedef data_t [`MPDMA_WIN_N-1:0] window_t;  // Element k in row-major order

    typedef struct packed {
        addr_t addr;
    } axi_ar_t;

    typedef struct packed {
        addr_t addr;
    } axi_aw_t;

    typedef struct packed {
        data_t data;
    } axi_w_t;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        WRITE,
        STEP,
        DONE
    } ctrl_state_t;

    // 1-based source coordinate one above or left of the window center
    // The last block pulls the window back by one so its mirrored edge stays inside
    function automatic dim_t win_origin(input dim_t block, input dim_t width);
        if (block == width) begin
            return width - dim_t'(1);
        end
        return block;
    endfunction

endpackage

`default_nettype wire

//--- mpdma_ctrl.sv
// Engine controller for the mirror-padding DMA
// Run FSM, configuration capture, 2x2 block stepping and done flag
`timescale 1ns/1ps
`default_nettype none

module mpdma_ctrl (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire mpdma_pkg::cfg_t    cfg_i,
    input  wire                     start_i,
    input  wire                     fetch_done_i,
    input  wire                     write_done_i,
    output logic                    done_o,
    output mpdma_pkg::cfg_t         cfg_o,
    output mpdma_pkg::blk_pos_t     pos_o,
    output logic                    fetch_req_o,
    output logic                    write_req_o
);

    mpdma_pkg::ctrl_state_t state;
    logic                   start_run;
    logic                   last_col;
    logic                   last_blk;

    assign start_run = (state == mpdma_pkg::IDLE) && start_i;

    // Blocks sit at rows and columns 0, 2, ..., W
    assign last_col = (pos_o.block_col >= cfg_o.mat_width);
    assign last_blk = last_col && (pos_o.block_row == cfg_o.mat_width);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= mpdma_pkg::IDLE;
            done_o      <= 1'b1;
            pos_o       <= '0;
            fetch_req_o <= 1'b0;
            write_req_o <= 1'b0;
        end else begin
            fetch_req_o <= 1'b0;  // Requests are single-cycle pulses
            write_req_o <= 1'b0;

            case (state)
                mpdma_pkg::IDLE: begin
                    if (start_i) begin
                        done_o      <= 1'b0;
                        pos_o       <= '0;
                        fetch_req_o <= 1'b1;
                        state       <= mpdma_pkg::FETCH;
                    end
                end

                mpdma_pkg::FETCH: begin
                    if (fetch_done_i) begin
                        write_req_o <= 1'b1;
                        state       <= mpdma_pkg::WRITE;
                    end
                end

                mpdma_pkg::WRITE: begin
                    if (write_done_i) begin
                        state <= mpdma_pkg::STEP;
                    end
                end

                mpdma_pkg::STEP: begin
                    if (last_blk) begin
                        done_o <= 1'b1;
                        state  <= mpdma_pkg::DONE;
                    end else begin
                        if (last_col) begin
                            pos_o.block_col <= '0;  // Wrap to the next block row
                            pos_o.block_row <= pos_o.block_row + mpdma_pkg::dim_t'(2);
                        end else begin
                            pos_o.block_col <= pos_o.block_col + mpdma_pkg::dim_t'(2);
                        end
                        fetch_req_o <= 1'b1;
                        state       <= mpdma_pkg::FETCH;
                    end
                end

                mpdma_pkg::DONE: begin
                    // Hold here until software releases start
                    if (!start_i) begin
                        state <= mpdma_pkg::IDLE;
                    end
                end

                default: begin
                    state <= mpdma_pkg::IDLE;
                end
            endcase
        end
    end

    // Configuration stays fixed for the whole run
    always_ff @(posedge clk) begin
        if (start_run) begin
            cfg_o <= cfg_i;
        end
    end

endmodule

`default_nettype wire

//--- mpdma_window_reader.sv
// Source window fetch for the mirror-padding DMA
// Nine sequential single-beat AXI reads with clamped addresses
// fill a 3x3 window register in row-major order
`timescale 1ns/1ps
`default_nettype none

`include "mpdma_settings.svh"

module mpdma_window_reader (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire mpdma_pkg::cfg_t    cfg_i,
    input  wire mpdma_pkg::blk_pos_t pos_i,
    input  wire                     fetch_req_i,
    output mpdma_pkg::axi_ar_t      ar_o,
    output logic                    arvalid_o,
    input  wire                     arready_i,
    input  wire mpdma_pkg::data_t   rdata_i,
    input  wire                     rvalid_i,
    output logic                    rready_o,
    output mpdma_pkg::window_t      window_o,
    output logic                    fetch_done_o
);

    localparam int CNT_W     = $clog2(`MPDMA_WIN_N);
    localparam int LAST_ELEM = `MPDMA_WIN_N - 1;

    logic [CNT_W-1:0] elem_cnt;  // Element being fetched
    logic [CNT_W-1:0] elem_row;
    logic [CNT_W-1:0] elem_col;
    mpdma_pkg::dim_t  org_row;
    mpdma_pkg::dim_t  org_col;
    mpdma_pkg::dim_t  src_row;
    mpdma_pkg::dim_t  src_col;
    mpdma_pkg::addr_t row_idx;
    mpdma_pkg::addr_t col_idx;
    logic             ar_fire;
    logic             r_fire;

    // Keeps a 1-based coordinate inside 1..W
    function automatic mpdma_pkg::dim_t clamp_dim(
        input mpdma_pkg::dim_t c,
        input mpdma_pkg::dim_t w
    );
        if (c == '0) begin
            return mpdma_pkg::dim_t'(1);
        end
        if (c > w) begin
            return w;
        end
        return c;
    endfunction

    assign ar_fire = arvalid_o && arready_i;
    assign r_fire  = rready_o && rvalid_i;

    // Address follows elem_cnt, so it is stable while arvalid is high
    always_comb begin
        elem_row = elem_cnt / CNT_W'(3);
        elem_col = elem_cnt % CNT_W'(3);
        org_row  = mpdma_pkg::win_origin(pos_i.block_row, cfg_i.mat_width);
        org_col  = mpdma_pkg::win_origin(pos_i.block_col, cfg_i.mat_width);
        src_row  = clamp_dim(org_row + mpdma_pkg::dim_t'(elem_row), cfg_i.mat_width);
        src_col  = clamp_dim(org_col + mpdma_pkg::dim_t'(elem_col), cfg_i.mat_width);
        row_idx  = mpdma_pkg::addr_t'(src_row - mpdma_pkg::dim_t'(1));
        col_idx  = mpdma_pkg::addr_t'(src_col - mpdma_pkg::dim_t'(1));
        ar_o.addr = cfg_i.src_addr
                  + (row_idx * mpdma_pkg::addr_t'(cfg_i.mat_width) + col_idx)
                  * `MPDMA_WORD_BYTES;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            elem_cnt     <= '0;
            arvalid_o    <= 1'b0;
            rready_o     <= 1'b0;
            fetch_done_o <= 1'b0;
        end else begin
            fetch_done_o <= 1'b0;

            if (fetch_req_i) begin
                elem_cnt  <= '0;
                arvalid_o <= 1'b1;
                rready_o  <= 1'b1;
            end

            if (ar_fire) begin
                arvalid_o <= 1'b0;
            end

            if (r_fire) begin
                rready_o <= 1'b0;
                if (elem_cnt == CNT_W'(LAST_ELEM)) begin
                    fetch_done_o <= 1'b1;
                end else begin
                    elem_cnt  <= elem_cnt + CNT_W'(1);  // Next element with AR and R together
                    arvalid_o <= 1'b1;
                    rready_o  <= 1'b1;
                end
            end
        end
    end

    // Window holds until the next fetch overwrites it
    always_ff @(posedge clk) begin
        if (r_fire) begin
            window_o[elem_cnt] <= rdata_i;
        end
    end

endmodule

`default_nettype wire

//--- mpdma_block_writer.sv
// Padded block output for the mirror-padding DMA
// Mirror mapping of the four block words onto the window and
// four single-beat AXI writes in TL, TR, BL, BR order
`timescale 1ns/1ps
`default_nettype none

`include "mpdma_settings.svh"

module mpdma_block_writer (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire mpdma_pkg::cfg_t    cfg_i,
    input  wire mpdma_pkg::blk_pos_t pos_i,
    input  wire mpdma_pkg::window_t window_i,
    input  wire                     write_req_i,
    output mpdma_pkg::axi_aw_t      aw_o,
    output logic                    awvalid_o,
    input  wire                     awready_i,
    output mpdma_pkg::axi_w_t       w_o,
    output logic                    wvalid_o,
    input  wire                     wready_i,
    input  wire                     bvalid_i,
    output logic                    bready_o,
    output logic                    write_done_o
);

    localparam int CNT_W     = $clog2(`MPDMA_BLK_N);
    localparam int LAST_WORD = `MPDMA_BLK_N - 1;
    localparam int IDX_W     = $clog2(`MPDMA_WIN_N);

    logic [CNT_W-1:0] word_cnt;  // Bit 1 selects the row, bit 0 the column
    mpdma_pkg::dim_t  out_row;
    mpdma_pkg::dim_t  out_col;
    mpdma_pkg::dim_t  src_row;
    mpdma_pkg::dim_t  src_col;
    mpdma_pkg::dim_t  org_row;
    mpdma_pkg::dim_t  org_col;
    logic [1:0]       rel_row;
    logic [1:0]       rel_col;
    logic [IDX_W-1:0] win_idx;
    mpdma_pkg::addr_t out_index;
    logic             aw_fire;
    logic             w_fire;
    logic             b_fire;

    // Output coordinate to 1-based source coordinate
    function automatic mpdma_pkg::dim_t mirror_dim(
        input mpdma_pkg::dim_t c,
        input mpdma_pkg::dim_t w
    );
        if (c == '0) begin
            return mpdma_pkg::dim_t'(2);
        end
        if (c == w + mpdma_pkg::dim_t'(1)) begin
            return w - mpdma_pkg::dim_t'(1);
        end
        return c;
    endfunction

    assign aw_fire = awvalid_o && awready_i;
    assign w_fire  = wvalid_o && wready_i;
    assign b_fire  = bready_o && bvalid_i;

    always_comb begin
        out_row = pos_i.block_row + mpdma_pkg::dim_t'(word_cnt[1]);
        out_col = pos_i.block_col + mpdma_pkg::dim_t'(word_cnt[0]);
        src_row = mirror_dim(out_row, cfg_i.mat_width);
        src_col = mirror_dim(out_col, cfg_i.mat_width);
        org_row = mpdma_pkg::win_origin(pos_i.block_row, cfg_i.mat_width);
        org_col = mpdma_pkg::win_origin(pos_i.block_col, cfg_i.mat_width);

        // Offset from the window's top-left element is always 0 to 2
        rel_row = 2'(src_row - org_row);
        rel_col = 2'(src_col - org_col);
        win_idx = IDX_W'(rel_row) * IDX_W'(3) + IDX_W'(rel_col);

        out_index = mpdma_pkg::addr_t'(out_row)
                  * (mpdma_pkg::addr_t'(cfg_i.mat_width) + mpdma_pkg::addr_t'(2))
                  + mpdma_pkg::addr_t'(out_col);
        aw_o.addr = cfg_i.dst_addr + out_index * `MPDMA_WORD_BYTES;
        w_o.data  = window_i[win_idx];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            word_cnt     <= '0;
            awvalid_o    <= 1'b0;
            wvalid_o     <= 1'b0;
            bready_o     <= 1'b0;
            write_done_o <= 1'b0;
        end else begin
            write_done_o <= 1'b0;

            if (write_req_i) begin
                word_cnt  <= '0;
                awvalid_o <= 1'b1;  // First AW on the next cycle
            end

            if (aw_fire) begin
                awvalid_o <= 1'b0;
                wvalid_o  <= 1'b1;
                bready_o  <= 1'b1;
            end

            if (w_fire) begin
                wvalid_o <= 1'b0;
            end

            // Response closes the word
            if (b_fire) begin
                bready_o <= 1'b0;
                if (word_cnt == CNT_W'(LAST_WORD)) begin
                    write_done_o <= 1'b1;
                end else begin
                    word_cnt  <= word_cnt + CNT_W'(1);
                    awvalid_o <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- mpdma_top.sv
// Top level of the mirror-padding DMA engine
// Controller, window reader and block writer on single-beat AXI channels
`timescale 1ns/1ps
`default_nettype none

module mpdma_top (
    input  wire                     clk,
    input  wire                     rst_n,

    input  wire mpdma_pkg::cfg_t    cfg_i,
    input  wire                     start_i,
    output logic                    done_o,

    // AR and R channels
    output mpdma_pkg::axi_ar_t      ar_o,
    output logic                    arvalid_o,
    input  wire                     arready_i,
    input  wire mpdma_pkg::data_t   rdata_i,
    input  wire                     rvalid_i,
    output logic                    rready_o,

    // AW, W and B channels
    output mpdma_pkg::axi_aw_t      aw_o,
    output logic                    awvalid_o,
    input  wire                     awready_i,
    output mpdma_pkg::axi_w_t       w_o,
    output logic                    wvalid_o,
    input  wire                     wready_i,
    input  wire                     bvalid_i,
    output logic                    bready_o
);

    mpdma_pkg::cfg_t     cfg;
    mpdma_pkg::blk_pos_t pos;
    mpdma_pkg::window_t  window;
    logic                fetch_req;
    logic                fetch_done;
    logic                write_req;
    logic                write_done;

    mpdma_ctrl i_mpdma_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_i        (cfg_i),
        .start_i      (start_i),
        .fetch_done_i (fetch_done),
        .write_done_i (write_done),
        .done_o       (done_o),
        .cfg_o        (cfg),
        .pos_o        (pos),
        .fetch_req_o  (fetch_req),
        .write_req_o  (write_req)
    );

    mpdma_window_reader i_mpdma_window_reader (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_i        (cfg),
        .pos_i        (pos),
        .fetch_req_i  (fetch_req),
        .ar_o         (ar_o),
        .arvalid_o    (arvalid_o),
        .arready_i    (arready_i),
        .rdata_i      (rdata_i),
        .rvalid_i     (rvalid_i),
        .rready_o     (rready_o),
        .window_o     (window),
        .fetch_done_o (fetch_done)
    );

    mpdma_block_writer i_mpdma_block_writer (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_i        (cfg),
        .pos_i        (pos),
        .window_i     (window),
        .write_req_i  (write_req),
        .aw_o         (aw_o),
        .awvalid_o    (awvalid_o),
        .awready_i    (awready_i),
        .w_o          (w_o),
        .wvalid_o     (wvalid_o),
        .wready_i     (wready_i),
        .bvalid_i     (bvalid_i),
        .bready_o     (bready_o),
        .write_done_o (write_done)
    );

endmodule

`default_nettype wire

//--- tb_axi_mem.sv
// Behavioral single-beat AXI memory for the DMA testbench
// Word array with address fill, per-channel stall inputs,
// a load port for source data and a pulse for every completed write
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire mpdma_pkg::addr_t   araddr_i,
    input  wire                     arvalid_i,
    output logic                    arready_o,
    output mpdma_pkg::data_t        rdata_o,
    output logic                    rvalid_o,
    input  wire                     rready_i,
    input  wire mpdma_pkg::addr_t   awaddr_i,
    input  wire                     awvalid_i,
    output logic                    awready_o,
    input  wire mpdma_pkg::data_t   wdata_i,
    input  wire                     wvalid_i,
    output logic                    wready_o,
    output logic                    bvalid_o,
    input  wire                     bready_i,
    input  wire [4:0]               stall_i,    // AR, R, AW, W, B from bit 0 up
    input  wire                     load_en_i,
    input  wire mpdma_pkg::addr_t   load_addr_i,
    input  wire mpdma_pkg::data_t   load_data_i,
    output logic                    wr_valid_o,
    output mpdma_pkg::addr_t        wr_addr_o
);

    mpdma_pkg::data_t mem [0:1023];  // 4 KiB, byte address bits 11:2
    mpdma_pkg::addr_t rd_addr;
    mpdma_pkg::addr_t wr_addr;
    mpdma_pkg::data_t wr_data;
    logic             rd_pend;
    logic             aw_got;
    logic             w_got;

    initial begin
        // Every word starts as a function of its own byte address
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 32'hc3a5_0000 ^ 32'(i * 4);
        end
        arready_o  = 1'b0;
        rvalid_o   = 1'b0;
        rdata_o    = '0;
        awready_o  = 1'b0;
        wready_o   = 1'b0;
        bvalid_o   = 1'b0;
        wr_valid_o = 1'b0;
        wr_addr_o  = '0;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            arready_o  <= 1'b0;
            rvalid_o   <= 1'b0;
            awready_o  <= 1'b0;
            wready_o   <= 1'b0;
            bvalid_o   <= 1'b0;
            rd_pend    <= 1'b0;
            aw_got     <= 1'b0;
            w_got      <= 1'b0;
            wr_valid_o <= 1'b0;
        end else begin
            wr_valid_o <= 1'b0;
            if (load_en_i) begin
                mem[load_addr_i[11:2]] <= load_data_i;
            end

            if (arvalid_i && arready_o) begin
                arready_o <= 1'b0;
                rd_addr   <= araddr_i;
                rd_pend   <= 1'b1;
            end else if (arvalid_i && !rd_pend && !stall_i[0]) begin
                arready_o <= 1'b1;
            end

            if (rvalid_o && rready_i) begin
                rvalid_o <= 1'b0;
                rd_pend  <= 1'b0;
            end else if (rd_pend && !rvalid_o && !stall_i[1]) begin
                rvalid_o <= 1'b1;
                rdata_o  <= mem[rd_addr[11:2]];
            end

            if (awvalid_i && awready_o) begin
                awready_o <= 1'b0;
                wr_addr   <= awaddr_i;
                aw_got    <= 1'b1;
            end else if (awvalid_i && !aw_got && !stall_i[2]) begin
                awready_o <= 1'b1;
            end

            if (wvalid_i && wready_o) begin
                wready_o <= 1'b0;
                wr_data  <= wdata_i;
                w_got    <= 1'b1;
            end else if (wvalid_i && !w_got && !stall_i[3]) begin
                wready_o <= 1'b1;
            end

            // Word lands in memory when its response is accepted
            if (bvalid_o && bready_i) begin
                bvalid_o           <= 1'b0;
                aw_got             <= 1'b0;
                w_got              <= 1'b0;
                mem[wr_addr[11:2]] <= wr_data;
                wr_valid_o         <= 1'b1;
                wr_addr_o          <= wr_addr;
            end else if (aw_got && w_got && !bvalid_o && !stall_i[4]) begin
                bvalid_o <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_mpdma.sv
// Testbench for the mirror-padding DMA engine
// Clock and reset, LFSR stimulus, value check, directed tests and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_mpdma;

    localparam logic [31:0] LFSR_SEED = 32'h9f90_7a86;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1

    // Reads and writes of one run plus the cycles spent loading its source
    function automatic int run_words(input int w);
        return 13 * ((w + 2) / 2) * ((w + 2) / 2) + w * w;
    endfunction

    // Longer than one whole block of a restarted run
    localparam int HOLD_CYCLES = 200;

    localparam int TOTAL_WORDS = run_words(4) + run_words(2) + run_words(6) + 2 * run_words(4);
    localparam int WATCHDOG_NS = (20 * TOTAL_WORDS + HOLD_CYCLES) * 40;

    logic                clk;
    logic                rst_n;
    mpdma_pkg::cfg_t     cfg;
    logic                start;
    logic                done;
    mpdma_pkg::axi_ar_t  ar;
    logic                arvalid;
    logic                arready;
    mpdma_pkg::data_t    rdata;
    logic                rvalid;
    logic                rready;
    mpdma_pkg::axi_aw_t  aw;
    logic                awvalid;
    logic                awready;
    mpdma_pkg::axi_w_t   w;
    logic                wvalid;
    logic                wready;
    logic                bvalid;
    logic                bready;
    logic [4:0]          stall;
    logic                stall_en;
    logic                load_en;
    mpdma_pkg::addr_t    load_addr;
    mpdma_pkg::data_t    load_data;
    logic                wr_log_valid;
    mpdma_pkg::addr_t    wr_log_addr;
    logic [31:0]         lfsr;
    mpdma_pkg::data_t    src_data [$];  // Row-major source matrix of the current run
    mpdma_pkg::addr_t    log_addr [$];
    int                  errors;
    int                  checks;

    mpdma_top i_mpdma_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_i     (cfg),
        .start_i   (start),
        .done_o    (done),
        .ar_o      (ar),
        .arvalid_o (arvalid),
        .arready_i (arready),
        .rdata_i   (rdata),
        .rvalid_i  (rvalid),
        .rready_o  (rready),
        .aw_o      (aw),
        .awvalid_o (awvalid),
        .awready_i (awready),
        .w_o       (w),
        .wvalid_o  (wvalid),
        .wready_i  (wready),
        .bvalid_i  (bvalid),
        .bready_o  (bready)
    );

    tb_axi_mem i_mem (
        .clk         (clk),
        .rst_n       (rst_n),
        .araddr_i    (ar.addr),
        .arvalid_i   (arvalid),
        .arready_o   (arready),
        .rdata_o     (rdata),
        .rvalid_o    (rvalid),
        .rready_i    (rready),
        .awaddr_i    (aw.addr),
        .awvalid_i   (awvalid),
        .awready_o   (awready),
        .wdata_i     (w.data),
        .wvalid_i    (wvalid),
        .wready_o    (wready),
        .bvalid_o    (bvalid),
        .bready_i    (bready),
        .stall_i     (stall),
        .load_en_i   (load_en),
        .load_addr_i (load_addr),
        .load_data_i (load_data),
        .wr_valid_o  (wr_log_valid),
        .wr_addr_o   (wr_log_addr)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic mpdma_pkg::data_t mem_word(input mpdma_pkg::addr_t addr);
        return i_mem.mem[addr[11:2]];
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // One stall decision per channel and cycle
    always @(posedge clk) begin : stall_gen
        logic [31:0] bits;
        if (stall_en) begin
            take_bits(5, bits);
            stall <= bits[4:0];
        end else begin
            stall <= '0;
        end
    end

    always @(posedge clk) begin
        if (wr_log_valid) begin
            log_addr.push_back(wr_log_addr);
        end
    end

    task automatic load_source(input mpdma_pkg::addr_t src, input int mw);
        logic [31:0] v;
        src_data.delete();
        for (int i = 0; i < mw * mw; i++) begin
            take_bits(32, v);
            src_data.push_back(v);
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= src + 32'(i * 4);
            load_data <= v;
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    // Start a run and wait for done to fall and rise again
    task automatic run_engine(input mpdma_pkg::addr_t src, input mpdma_pkg::addr_t dst,
                              input int mw, input bit hold_start);
        log_addr.delete();
        @(posedge clk);
        cfg.src_addr  <= src;
        cfg.dst_addr  <= dst;
        cfg.mat_width <= mpdma_pkg::dim_t'(mw);
        start         <= 1'b1;
        @(negedge clk);
        while (done) @(negedge clk);
        while (!done) @(negedge clk);
        if (!hold_start) begin
            @(posedge clk);
            start <= 1'b0;
        end
    endtask

    task automatic verify_run(input string name, input mpdma_pkg::addr_t src,
                              input mpdma_pkg::addr_t dst, input int mw);
        int               n;
        int               sr;
        int               sc;
        int               off;
        mpdma_pkg::addr_t a;
        bit               seen [int];
        n = mw + 2;
        check({name, " write count"}, 32'(n * n), 32'(log_addr.size()));
        foreach (log_addr[i]) begin
            a = log_addr[i];
            if (a < dst || a >= dst + 32'(n * n * 4) || a[1:0] != 2'b00) begin
                errors++;
                $display("%s: write to %h lies outside the destination region", name, a);
            end else begin
                off = int'((a - dst) >> 2);
                if (seen.exists(off)) begin
                    errors++;
                    $display("%s: address %h was written more than once", name, a);
                end
                seen[off] = 1'b1;
            end
        end
        for (int r = 0; r < n; r++) begin
            for (int c = 0; c < n; c++) begin
                sr = (r == 0) ? 2 : ((r == n - 1) ? mw - 1 : r);  // Mirror about the edge
                sc = (c == 0) ? 2 : ((c == n - 1) ? mw - 1 : c);
                check($sformatf("%s out(%0d,%0d)", name, r, c),
                      src_data[(sr - 1) * mw + sc - 1], mem_word(dst + 32'((r * n + c) * 4)));
            end
        end
        for (int i = 0; i < mw * mw; i++) begin
            check($sformatf("%s src[%0d] unchanged", name, i),
                  src_data[i], mem_word(src + 32'(i * 4)));
        end
    endtask

    task automatic test_reset_values();
        @(negedge clk);
        check("reset done_o", 32'd1, 32'(done));
        check("reset arvalid_o", 32'd0, 32'(arvalid));
        check("reset rready_o", 32'd0, 32'(rready));
        check("reset awvalid_o", 32'd0, 32'(awvalid));
        check("reset wvalid_o", 32'd0, 32'(wvalid));
        check("reset bready_o", 32'd0, 32'(bready));
    endtask

    task automatic test_w4_no_stall();
        load_source(32'h0000_0000, 4);
        run_engine(32'h0000_0000, 32'h0000_0100, 4, 1'b0);
        verify_run("w4 no stall", 32'h0000_0000, 32'h0000_0100, 4);
    endtask

    task automatic test_w2_minimal();
        load_source(32'h0000_0200, 2);
        run_engine(32'h0000_0200, 32'h0000_0240, 2, 1'b0);
        verify_run("w2 minimal", 32'h0000_0200, 32'h0000_0240, 2);
    endtask

    task automatic test_w6_stalls();
        load_source(32'h0000_0300, 6);
        @(posedge clk);
        stall_en <= 1'b1;
        run_engine(32'h0000_0300, 32'h0000_0400, 6, 1'b0);
        stall_en <= 1'b0;
        verify_run("w6 stalls", 32'h0000_0300, 32'h0000_0400, 6);
    endtask

    task automatic test_done_handshake();
        load_source(32'h0000_0600, 4);
        run_engine(32'h0000_0600, 32'h0000_0700, 4, 1'b1);
        repeat (HOLD_CYCLES) @(negedge clk);
        check("start held write count", 32'd36, 32'(log_addr.size()));
        check("start held done_o", 32'd1, 32'(done));
        verify_run("first run", 32'h0000_0600, 32'h0000_0700, 4);
        @(posedge clk);
        start <= 1'b0;
        repeat (2) @(posedge clk);
        load_source(32'h0000_0900, 4);
        run_engine(32'h0000_0900, 32'h0000_0a00, 4, 1'b0);
        verify_run("second run", 32'h0000_0900, 32'h0000_0a00, 4);
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        cfg       = '0;
        start     = 1'b0;
        stall     = '0;
        stall_en  = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        lfsr      = LFSR_SEED;
        errors    = 0;
        checks    = 0;

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        test_reset_values();
        test_w4_no_stall();
        test_w2_minimal();
        test_w6_stalls();
        test_done_handshake();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Hard limit on the whole run
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the engine did not finish within %0d ns", WATCHDOG_NS);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+.
mpdma_pkg.sv
mpdma_ctrl.sv
mpdma_window_reader.sv
mpdma_block_writer.sv
mpdma_top.sv
tb_axi_mem.sv
tb_mpdma.sv

//--- Makefile
# Verilator build and run for the mirror-padding DMA testbench

VERILATOR ?= verilator
TOP       ?= tb_mpdma
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS    := $(shell grep -v '^+' $(FILELIST))
HEADERS := mpdma_settings.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, the header or the file list changes
$(BIN): $(SRCS) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "All tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
